// ==== logic/lstm_pkg.sv ====
package lstm_pkg;

    // fixed point format, Q1.7
    localparam int DATA_WIDTH = 8;
    localparam int FRAC_BITS  = 7;
    localparam int LANES      = 4;

    // table covers pre-activations -2.0 .. +2.0
    localparam int IDX_SAT_HI = 255;
    localparam int IDX_SAT_LO = -256;

    typedef logic signed [DATA_WIDTH-1:0] sample_t;

    typedef sample_t [LANES-1:0] vec_t; // lane 0 in the low byte

    // input (w_*) and recurrent (r_*) weights, peepholes last
    typedef struct packed {
        vec_t    w_i;
        vec_t    w_z;
        vec_t    w_f;
        vec_t    w_o;
        vec_t    r_i;
        vec_t    r_z;
        vec_t    r_f;
        vec_t    r_o;
        sample_t p_i;
        sample_t p_f;
        sample_t p_o;
    } weight_set_t;

    // everything one cell step consumes
    typedef struct packed {
        vec_t        x;
        vec_t        y_prev;
        weight_set_t weights;
    } step_in_t;

    typedef enum logic [1:0] {
        GATE_I,
        GATE_Z,
        GATE_F,
        GATE_O
    } gate_t;

    typedef logic [DATA_WIDTH-1:0] act_t; // unsigned table output

    typedef logic signed [DATA_WIDTH-1:0] act_index_t;

endpackage

// ==== logic/step_intake.sv ====
`timescale 1ns/1ps

module step_intake (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               step_req,
    input  lstm_pkg::step_in_t step_in,
    output logic               step_ack,
    input  logic               step_done,
    output logic               start,
    output lstm_pkg::step_in_t operands
);

    logic in_flight; // set from acceptance until the result is taken
    logic accept;

    // new request, previous handshake closed and no step pending
    assign accept = step_req && !step_ack && !in_flight;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_ack  <= 1'b0;
            start     <= 1'b0;
            in_flight <= 1'b0;
        end else begin
            start <= 1'b0;
            if (accept) begin
                step_ack  <= 1'b1;
                start     <= 1'b1; // same cycle as ack rising
                in_flight <= 1'b1;
            end else if (step_ack && !step_req) begin
                step_ack <= 1'b0;
            end
            if (step_done)
                in_flight <= 1'b0;
        end
    end

    // operands stay frozen for the whole step
    always_ff @(posedge clk) begin
        if (accept)
            operands <= step_in;
    end

endmodule

// ==== logic/gate_dot_pipe.sv ====
`timescale 1ns/1ps

module gate_dot_pipe #(
    parameter int ACC_WIDTH = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        issue_valid,
    input  lstm_pkg::gate_t             issue_gate,
    input  lstm_pkg::step_in_t          operands,
    output logic                        dot_valid,
    output lstm_pkg::gate_t             dot_gate,
    output logic signed [ACC_WIDTH-1:0] dot_sum
);

    localparam int PROD_WIDTH = 2 * lstm_pkg::DATA_WIDTH;

    lstm_pkg::vec_t               w_sel;
    lstm_pkg::vec_t               r_sel;
    logic signed [PROD_WIDTH-1:0] prod_w [lstm_pkg::LANES];
    logic signed [PROD_WIDTH-1:0] prod_r [lstm_pkg::LANES];
    logic                         s1_valid;
    lstm_pkg::gate_t              s1_gate;
    logic signed [ACC_WIDTH-1:0]  sum_w;
    logic signed [ACC_WIDTH-1:0]  sum_r;

    // weight rows of the issued gate
    always_comb begin
        case (issue_gate)
            lstm_pkg::GATE_I: begin
                w_sel = operands.weights.w_i;
                r_sel = operands.weights.r_i;
            end
            lstm_pkg::GATE_Z: begin
                w_sel = operands.weights.w_z;
                r_sel = operands.weights.r_z;
            end
            lstm_pkg::GATE_F: begin
                w_sel = operands.weights.w_f;
                r_sel = operands.weights.r_f;
            end
            default: begin
                w_sel = operands.weights.w_o;
                r_sel = operands.weights.r_o;
            end
        endcase
    end

    // stage one, eight full 8x8 lane products
    always_ff @(posedge clk) begin
        for (int k = 0; k < lstm_pkg::LANES; k++) begin
            prod_w[k] <= $signed(w_sel[k]) * $signed(operands.x[k]);
            prod_r[k] <= $signed(r_sel[k]) * $signed(operands.y_prev[k]);
        end
        s1_gate <= issue_gate;
    end

    // group sums wrap at ACC_WIDTH
    always_comb begin
        sum_w = '0;
        sum_r = '0;
        for (int k = 0; k < lstm_pkg::LANES; k++) begin
            sum_w = sum_w + prod_w[k];
            sum_r = sum_r + prod_r[k];
        end
    end

    // stage two
    always_ff @(posedge clk) begin
        dot_sum  <= (sum_w >>> lstm_pkg::FRAC_BITS) + (sum_r >>> lstm_pkg::FRAC_BITS);
        dot_gate <= s1_gate;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            dot_valid <= 1'b0;
        end else begin
            s1_valid  <= issue_valid;
            dot_valid <= s1_valid;
        end
    end

endmodule

// ==== logic/cell_update.sv ====
`timescale 1ns/1ps

module cell_update #(
    parameter int ACC_WIDTH = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  lstm_pkg::step_in_t          operands,
    input  logic                        dot_valid,
    input  lstm_pkg::gate_t             dot_gate,
    input  logic signed [ACC_WIDTH-1:0] dot_sum,
    output logic                        issue_valid,
    output lstm_pkg::gate_t             issue_gate,
    output logic                        lookup_start,
    output logic signed [ACC_WIDTH-1:0] lookup_pre,
    input  logic                        lookup_done,
    input  lstm_pkg::act_t              lookup_value,
    output logic                        y_valid,
    output lstm_pkg::sample_t           y
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1; // wait for operand, fire lookup
    localparam logic [1:0] S_WAIT = 2'd2; // lookup in progress

    // lookup order i, z, f, c, o
    localparam logic [2:0] LK_C = 3'd3;
    localparam logic [2:0] LK_O = 3'd4;

    logic [1:0]                  state;
    logic [2:0]                  lk;
    logic signed [ACC_WIDTH-1:0] c;     // cell state, survives steps
    logic signed [ACC_WIDTH-1:0] dot_q [4];
    logic [3:0]                  dot_have;
    lstm_pkg::act_t              act_q [4]; // a_i, a_z, a_f, a_c
    logic signed [ACC_WIDTH-1:0] c_new;
    logic signed [ACC_WIDTH-1:0] pre_next;
    logic                        ready;
    logic signed [ACC_WIDTH-1:0] y_full;

    // Q1.7 product, wraps at ACC_WIDTH before the shift
    function automatic logic signed [ACC_WIDTH-1:0] q_mul(
        input logic signed [ACC_WIDTH-1:0] a,
        input logic signed [ACC_WIDTH-1:0] b
    );
        logic signed [ACC_WIDTH-1:0] prod;
        prod = a * b;
        return prod >>> lstm_pkg::FRAC_BITS;
    endfunction

    // four gate issues back to back after start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
            issue_gate  <= lstm_pkg::GATE_I;
        end else if (start) begin
            issue_valid <= 1'b1;
            issue_gate  <= lstm_pkg::GATE_I;
        end else if (issue_valid) begin
            if (issue_gate == lstm_pkg::GATE_O)
                issue_valid <= 1'b0;
            else
                issue_gate <= lstm_pkg::gate_t'(issue_gate + 2'd1);
        end
    end

    // dot sums parked per gate until their lookup
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            dot_have <= '0;
        else if (start)
            dot_have <= '0;
        else if (dot_valid)
            dot_have[dot_gate] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (dot_valid)
            dot_q[dot_gate] <= dot_sum;
    end

    assign c_new = q_mul(act_q[1], act_q[0]) + q_mul(c, act_q[2]);

    // pre-activation of the current lookup
    always_comb begin
        pre_next = c_new;
        ready    = 1'b1;
        case (lk)
            3'd0: begin
                pre_next = dot_q[lstm_pkg::GATE_I] + q_mul(operands.weights.p_i, c);
                ready    = dot_have[lstm_pkg::GATE_I];
            end
            3'd1: begin
                pre_next = dot_q[lstm_pkg::GATE_Z];
                ready    = dot_have[lstm_pkg::GATE_Z];
            end
            3'd2: begin
                pre_next = dot_q[lstm_pkg::GATE_F] + q_mul(operands.weights.p_f, c);
                ready    = dot_have[lstm_pkg::GATE_F];
            end
            LK_C: ;
            default: begin
                // c already holds c_new here
                pre_next = dot_q[lstm_pkg::GATE_O] + q_mul(operands.weights.p_o, c);
                ready    = dot_have[lstm_pkg::GATE_O];
            end
        endcase
    end

    assign y_full = q_mul(lookup_value, act_q[3]); // a_o * a_c

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            lk           <= 3'd0;
            c            <= '0;
            lookup_start <= 1'b0;
            y_valid      <= 1'b0;
        end else begin
            lookup_start <= 1'b0;
            y_valid      <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        lk    <= 3'd0;
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (ready) begin
                        lookup_start <= 1'b1;
                        state        <= S_WAIT;
                        if (lk == LK_C)
                            c <= c_new; // i and f peepholes are done with old c
                    end
                end
                S_WAIT: begin
                    if (lookup_done) begin
                        if (lk == LK_O) begin
                            y_valid <= 1'b1;
                            state   <= S_IDLE;
                        end else begin
                            lk    <= lk + 3'd1;
                            state <= S_REQ;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_REQ && ready)
            lookup_pre <= pre_next;
        if (state == S_WAIT && lookup_done) begin
            if (lk == LK_O)
                y <= y_full[lstm_pkg::DATA_WIDTH-1:0];
            else
                act_q[lk[1:0]] <= lookup_value;
        end
    end

endmodule

// ==== logic/act_lookup_port.sv ====
`timescale 1ns/1ps

module act_lookup_port #(
    parameter int ACC_WIDTH = 16
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        lookup_start,
    input  logic signed [ACC_WIDTH-1:0] lookup_pre,
    output logic                        lookup_done,
    output lstm_pkg::act_t              lookup_value,
    output logic                        act_req,
    output lstm_pkg::act_index_t        act_index,
    input  logic                        act_ack,
    input  lstm_pkg::act_t              act_value
);

    localparam logic [1:0] P_IDLE    = 2'd0;
    localparam logic [1:0] P_REQ     = 2'd1;
    localparam logic [1:0] P_RELEASE = 2'd2; // waiting for ack to drop

    logic [1:0]                  state;
    logic signed [ACC_WIDTH-1:0] pre_half;
    lstm_pkg::act_index_t        idx_next;

    // clamp to the table range, then halve to an 8-bit address
    always_comb begin
        pre_half = lookup_pre >>> 1;
        if (lookup_pre > lstm_pkg::IDX_SAT_HI)
            idx_next = {1'b0, {(lstm_pkg::DATA_WIDTH-1){1'b1}}};  // 127
        else if (lookup_pre < lstm_pkg::IDX_SAT_LO)
            idx_next = {1'b1, {(lstm_pkg::DATA_WIDTH-1){1'b0}}};  // -128
        else
            idx_next = pre_half[lstm_pkg::DATA_WIDTH-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= P_IDLE;
            act_req     <= 1'b0;
            lookup_done <= 1'b0;
        end else begin
            lookup_done <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (lookup_start) begin
                        act_req <= 1'b1;
                        state   <= P_REQ;
                    end
                end
                P_REQ: begin
                    if (act_ack) begin
                        act_req <= 1'b0;
                        state   <= P_RELEASE;
                    end
                end
                P_RELEASE: begin
                    if (!act_ack) begin
                        lookup_done <= 1'b1;
                        state       <= P_IDLE;
                    end
                end
                default: state <= P_IDLE;
            endcase
        end
    end

    // index held through the request, value taken on first ack cycle
    always_ff @(posedge clk) begin
        if (state == P_IDLE && lookup_start)
            act_index <= idx_next;
        if (state == P_REQ && act_ack)
            lookup_value <= act_value;
    end

endmodule

// ==== logic/result_output.sv ====
`timescale 1ns/1ps

module result_output (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              y_valid,
    input  lstm_pkg::sample_t y,
    output logic              result_req,
    output lstm_pkg::sample_t result_y,
    input  logic              result_ack,
    output logic              step_done
);

    logic ack_seen; // req dropped, waiting for ack low

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_req <= 1'b0;
            ack_seen   <= 1'b0;
            step_done  <= 1'b0;
        end else begin
            step_done <= 1'b0;
            if (y_valid) begin
                result_req <= 1'b1;
            end else if (result_req && result_ack) begin
                result_req <= 1'b0;
                ack_seen   <= 1'b1;
            end else if (ack_seen && !result_ack) begin
                ack_seen  <= 1'b0;
                step_done <= 1'b1; // frees the intake for the next step
            end
        end
    end

    always_ff @(posedge clk) begin
        if (y_valid)
            result_y <= y;
    end

endmodule

// ==== logic/lstm_cell_top.sv ====
`timescale 1ns/1ps

module lstm_cell_top #(
    parameter int ACC_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 step_req,
    input  lstm_pkg::step_in_t   step_in,
    output logic                 step_ack,
    output logic                 act_req,
    output lstm_pkg::act_index_t act_index,
    input  logic                 act_ack,
    input  lstm_pkg::act_t       act_value,
    output logic                 result_req,
    output lstm_pkg::sample_t    result_y,
    input  logic                 result_ack
);

    lstm_pkg::step_in_t          operands;
    logic                        start;
    logic                        step_done;
    logic                        issue_valid;
    lstm_pkg::gate_t             issue_gate;
    logic                        dot_valid;
    lstm_pkg::gate_t             dot_gate;
    logic signed [ACC_WIDTH-1:0] dot_sum;
    logic                        lookup_start;
    logic signed [ACC_WIDTH-1:0] lookup_pre;
    logic                        lookup_done;
    lstm_pkg::act_t              lookup_value;
    logic                        y_valid;
    lstm_pkg::sample_t           y;

    step_intake u_step_intake (
        .clk       (clk),
        .rst_n     (rst_n),
        .step_req  (step_req),
        .step_in   (step_in),
        .step_ack  (step_ack),
        .step_done (step_done),
        .start     (start),
        .operands  (operands)
    );

    gate_dot_pipe #(.ACC_WIDTH(ACC_WIDTH)) u_gate_dot_pipe (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue_gate  (issue_gate),
        .operands    (operands),
        .dot_valid   (dot_valid),
        .dot_gate    (dot_gate),
        .dot_sum     (dot_sum)
    );

    cell_update #(.ACC_WIDTH(ACC_WIDTH)) u_cell_update (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .operands     (operands),
        .dot_valid    (dot_valid),
        .dot_gate     (dot_gate),
        .dot_sum      (dot_sum),
        .issue_valid  (issue_valid),
        .issue_gate   (issue_gate),
        .lookup_start (lookup_start),
        .lookup_pre   (lookup_pre),
        .lookup_done  (lookup_done),
        .lookup_value (lookup_value),
        .y_valid      (y_valid),
        .y            (y)
    );

    act_lookup_port #(.ACC_WIDTH(ACC_WIDTH)) u_act_lookup_port (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_start (lookup_start),
        .lookup_pre   (lookup_pre),
        .lookup_done  (lookup_done),
        .lookup_value (lookup_value),
        .act_req      (act_req),
        .act_index    (act_index),
        .act_ack      (act_ack),
        .act_value    (act_value)
    );

    result_output u_result_output (
        .clk        (clk),
        .rst_n      (rst_n),
        .y_valid    (y_valid),
        .y          (y),
        .result_req (result_req),
        .result_y   (result_y),
        .result_ack (result_ack),
        .step_done  (step_done)
    );

endmodule

// ==== test/lstm_model.svh ====
`ifndef LSTM_MODEL_SVH
`define LSTM_MODEL_SVH

typedef logic signed [ACC_WIDTH-1:0] acc_t;

// low ACC_WIDTH bits of a wide result
function automatic acc_t wrap_acc(input longint v);
    acc_t r;
    r = v[ACC_WIDTH-1:0];
    return r;
endfunction

// Q1.7 product, wrapped before the shift
function automatic acc_t fix_mul(input longint a, input longint b);
    acc_t p;
    p = wrap_acc(a * b);
    return p >>> lstm_pkg::FRAC_BITS;
endfunction

function automatic acc_t dot4(input lstm_pkg::vec_t w, input lstm_pkg::vec_t v);
    longint sum;
    acc_t   t;
    sum = 0;
    for (int k = 0; k < lstm_pkg::LANES; k++)
        sum += longint'(w[k]) * longint'(v[k]);
    t = wrap_acc(sum);
    return t >>> lstm_pkg::FRAC_BITS;
endfunction

// clamp to +-2.0, otherwise halve
function automatic lstm_pkg::act_index_t lookup_index(input acc_t s);
    acc_t half;
    half = s >>> 1;
    if (s > lstm_pkg::IDX_SAT_HI)
        return lstm_pkg::act_index_t'(127);
    else if (s < lstm_pkg::IDX_SAT_LO)
        return lstm_pkg::act_index_t'(-128);
    return half[lstm_pkg::DATA_WIDTH-1:0];
endfunction

// one cell step, indices in lookup order i z f c o
task automatic model_step(
    input  lstm_pkg::step_in_t   s,
    ref    lstm_pkg::act_t       tbl [256],
    ref    acc_t                 c,
    output lstm_pkg::act_index_t idx [5],
    output lstm_pkg::sample_t    y
);
    lstm_pkg::weight_set_t w;
    acc_t                  pre;
    acc_t                  c_new;
    acc_t                  y_full;
    lstm_pkg::act_t        a [5];
    w      = s.weights;
    pre    = dot4(w.w_i, s.x) + dot4(w.r_i, s.y_prev) + fix_mul(w.p_i, c);
    idx[0] = lookup_index(pre);
    a[0]   = tbl[$unsigned(idx[0])];
    pre    = dot4(w.w_z, s.x) + dot4(w.r_z, s.y_prev);
    idx[1] = lookup_index(pre);
    a[1]   = tbl[$unsigned(idx[1])];
    pre    = dot4(w.w_f, s.x) + dot4(w.r_f, s.y_prev) + fix_mul(w.p_f, c);
    idx[2] = lookup_index(pre);
    a[2]   = tbl[$unsigned(idx[2])];
    c_new  = fix_mul(a[1], a[0]) + fix_mul(c, a[2]); // table values zero-extended
    idx[3] = lookup_index(c_new);
    a[3]   = tbl[$unsigned(idx[3])];
    pre    = dot4(w.w_o, s.x) + dot4(w.r_o, s.y_prev) + fix_mul(w.p_o, c_new);
    idx[4] = lookup_index(pre);
    a[4]   = tbl[$unsigned(idx[4])];
    y_full = fix_mul(a[4], a[3]);
    y      = y_full[lstm_pkg::DATA_WIDTH-1:0];
    c      = c_new;
endtask

`endif

// ==== test/tb_lstm_cell.sv ====
`timescale 1ns/1ps

module tb_lstm_cell;

    localparam int ACC_WIDTH       = 16;
    localparam int STEPS           = 40;
    localparam int ISOLATED        = 4; // steps each run alone after a reset
    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int CYCLES_PER_STEP = 200;
    localparam int WATCHDOG_NS     =
        (STEPS * CYCLES_PER_STEP + ISOLATED * (RESET_CYCLES + 2)) * CLK_PERIOD;

    `include "lstm_model.svh"

    logic                 clk;
    logic                 rst_n;
    logic                 step_req;
    lstm_pkg::step_in_t   step_in;
    logic                 step_ack;
    logic                 act_req;
    lstm_pkg::act_index_t act_index;
    logic                 act_ack;
    lstm_pkg::act_t       act_value;
    logic                 result_req;
    lstm_pkg::sample_t    result_y;
    logic                 result_ack;

    lstm_pkg::act_t       act_table [256];
    int                   ack_delay [STEPS * 5];
    int                   result_delay [STEPS];
    int                   lookups_served;
    int                   done_steps;
    int                   tests;
    int                   errors;
    int                   sat_hi; // expected indices at 127
    int                   sat_lo; // expected indices at -128
    acc_t                 model_c; // model cell state
    lstm_pkg::act_index_t exp_idx [$];
    lstm_pkg::sample_t    exp_y [$];
    lstm_pkg::act_index_t seen_idx [$];
    string                lk_name [5] = '{"i", "z", "f", "c", "o"};
    logic                 busy;
    logic                 step_ack_q;
    logic                 result_ack_q;

    lstm_cell_top #(.ACC_WIDTH(ACC_WIDTH)) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .step_req   (step_req),
        .step_in    (step_in),
        .step_ack   (step_ack),
        .act_req    (act_req),
        .act_index  (act_index),
        .act_ack    (act_ack),
        .act_value  (act_value),
        .result_req (result_req),
        .result_y   (result_y),
        .result_ack (result_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_sample(input string name, input lstm_pkg::sample_t exp,
                                input lstm_pkg::sample_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_index(input string name, input lstm_pkg::act_index_t exp,
                               input lstm_pkg::act_index_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    function automatic lstm_pkg::sample_t rand_sample(input int mag);
        return lstm_pkg::sample_t'(int'($urandom_range(2 * mag - 1, 0)) - mag);
    endfunction

    function automatic lstm_pkg::vec_t rand_vec(input int mag);
        lstm_pkg::vec_t v;
        for (int k = 0; k < lstm_pkg::LANES; k++)
            v[k] = rand_sample(mag);
        return v;
    endfunction

    // full-range inputs with weights limited to +-mag
    function automatic lstm_pkg::step_in_t make_step(input int mag);
        lstm_pkg::step_in_t s;
        s.x           = rand_vec(128);
        s.y_prev      = rand_vec(128);
        s.weights.w_i = rand_vec(mag);
        s.weights.w_z = rand_vec(mag);
        s.weights.w_f = rand_vec(mag);
        s.weights.w_o = rand_vec(mag);
        s.weights.r_i = rand_vec(mag);
        s.weights.r_z = rand_vec(mag);
        s.weights.r_f = rand_vec(mag);
        s.weights.r_o = rand_vec(mag);
        s.weights.p_i = rand_sample(mag);
        s.weights.p_f = rand_sample(mag);
        s.weights.p_o = rand_sample(mag);
        return s;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        tests++;
        if (step_ack !== 1'b0 || act_req !== 1'b0 || result_req !== 1'b0) begin
            errors++;
            $display("reset: a request or acknowledge output is not low (%b %b %b)",
                     step_ack, act_req, result_req);
        end else begin
            $display("reset: outputs low");
        end
    endtask

    // four-phase request on the step input
    task automatic send_step(input lstm_pkg::step_in_t s);
        @(posedge clk);
        step_in  <= s;
        step_req <= 1'b1;
        do @(posedge clk); while (!step_ack);
        step_req <= 1'b0;
        do @(posedge clk); while (step_ack);
    endtask

    task automatic compare_step(input int n);
        lstm_pkg::act_index_t want;
        for (int k = 0; k < 5; k++) begin
            want = exp_idx.pop_front();
            if (want == 127)
                sat_hi++;
            else if (want == -128)
                sat_lo++;
            if (seen_idx.size() == 0) begin
                errors++;
                $display("step %0d: lookup %s never reached the table", n, lk_name[k]);
            end else begin
                check_index($sformatf("step %0d index %s", n, lk_name[k]), want,
                            seen_idx.pop_front());
            end
        end
        if (seen_idx.size() != 0) begin
            errors++;
            $display("step %0d: %0d table lookups more than expected", n, seen_idx.size());
            seen_idx.delete();
        end
        check_sample($sformatf("step %0d y", n), exp_y.pop_front(), result_y);
    endtask

    initial begin : main_sequence
        lstm_pkg::step_in_t   s;
        lstm_pkg::act_index_t idx [5];
        lstm_pkg::sample_t    y;
        int                   mag;
        clk            = 1'b0;
        rst_n          = 1'b0;
        step_req       = 1'b0;
        step_in        = '0;
        act_ack        = 1'b0;
        act_value      = '0;
        result_ack     = 1'b0;
        lookups_served = 0;
        done_steps     = 0;
        tests          = 0;
        errors         = 0;
        sat_hi         = 0;
        sat_lo         = 0;
        model_c        = '0;
        void'($urandom(71088));
        foreach (act_table[a])
            act_table[a] = lstm_pkg::act_t'($urandom_range(255, 0));
        foreach (ack_delay[k])
            ack_delay[k] = $urandom_range(5, 0);
        foreach (result_delay[k])
            result_delay[k] = $urandom_range(6, 0);
        for (int n = 0; n < STEPS; n++) begin
            if (n < ISOLATED) begin
                wait (done_steps == n); // previous step fully closed
                apply_reset();
                model_c = '0;
            end
            mag = (n % 3 == 0) ? 128 : ((n % 3 == 1) ? 16 : 48);
            s   = make_step(mag);
            model_step(s, act_table, model_c, idx, y);
            foreach (idx[k])
                exp_idx.push_back(idx[k]);
            exp_y.push_back(y);
            send_step(s); // next one may wait on a pending result
        end
        wait (done_steps == STEPS);
        repeat (2) @(posedge clk);
        tests++;
        if (sat_hi == 0 || sat_lo == 0) begin
            errors++;
            $display("saturation: the indices never reached both 127 and -128 (%0d %0d)",
                     sat_hi, sat_lo);
        end else begin
            $display("saturation: %0d indices at 127, %0d at -128", sat_hi, sat_lo);
        end
        $display("%0d tests, %0d failures", tests, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // activation table answering after a random delay
    initial begin : table_responder
        forever begin
            @(posedge clk);
            if (rst_n && act_req && !act_ack) begin
                seen_idx.push_back(act_index);
                repeat (ack_delay[lookups_served % (STEPS * 5)]) @(posedge clk);
                act_value <= act_table[$unsigned(act_index)];
                act_ack   <= 1'b1;
                do @(posedge clk); while (act_req);
                act_ack <= 1'b0;
                lookups_served++;
            end
        end
    end

    initial begin : result_acceptor
        int errs_before;
        forever begin
            @(posedge clk);
            if (rst_n && result_req && !result_ack) begin
                repeat (result_delay[done_steps % STEPS]) @(posedge clk);
                errs_before = errors;
                compare_step(done_steps);
                result_ack <= 1'b1;
                do @(posedge clk); while (result_req);
                result_ack <= 1'b0;
                tests++;
                $display("step %0d %s, y = %0d", done_steps,
                         (errors == errs_before) ? "ok" : "mismatch", result_y);
                done_steps++;
            end
        end
    end

    // a step is busy from step_ack rising until result_ack falls
    always @(posedge clk) begin : handshake_monitor
        if (!rst_n) begin
            busy         <= 1'b0;
            step_ack_q   <= 1'b0;
            result_ack_q <= 1'b0;
        end else begin
            if (step_ack && !step_ack_q) begin
                if (busy) begin
                    errors++;
                    $display("step_ack rose while the previous result was still pending");
                end
                busy <= 1'b1;
            end else if (result_ack_q && !result_ack) begin
                busy <= 1'b0;
            end
            step_ack_q   <= step_ack;
            result_ack_q <= result_ack;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: only %0d of %0d steps completed in %0d ns",
                 done_steps, STEPS, WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

// ==== lstm_cell.f ====
logic/lstm_pkg.sv
logic/step_intake.sv
logic/gate_dot_pipe.sv
logic/cell_update.sv
logic/act_lookup_port.sv
logic/result_output.sv
logic/lstm_cell_top.sv
+incdir+test
test/tb_lstm_cell.sv
